//--- sim.f
+incdir+verilog
verilog/branchPkg.sv
verilog/branchForwardUnit.sv
verilog/branchComp.sv
verilog/branchDecide.sv
verilog/idBranchTop.sv
bench/idBranchClock.sv
bench/idBranch_checker.sv
bench/idBranchTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module idBranchTb -o idBranchSim

./obj_dir/idBranchSim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- bench/idBranchTb.sv
`timescale 1ns/10ps

`include "branch_defines.svh"

module idBranchTb import branchPkg::*; ();

    typedef struct {
        string            name;
        idBranchS         item;
        memFwdS           mem;
        wbFwdS            wb;
        logic             expTaken;
        logic [`XLEN-1:0] expTarget;
    } vectorS;

    localparam int               CLK_PERIOD   = 20;
    localparam int               RESET_CYCLES = 4;
    localparam logic [`XLEN-1:0] PC0          = 32'h0000_1000;

    logic     clk;
    logic     rstN;
    idBranchS branchIn;
    memFwdS   memStage;
    wbFwdS    wbStage;
    redirectS redirect;
    vectorS   vectors[$];

    // BEQ BNE BLT BGE BLTU BGEU
    logic [2:0] condList [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    idBranchClock clockGen_i (
        .clk  (clk),
        .rstN (rstN)
    );

    idBranchTop idBranchTop_i (
        .clk      (clk),
        .rstN     (rstN),
        .branchIn (branchIn),
        .memStage (memStage),
        .wbStage  (wbStage),
        .redirect (redirect)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Encoders and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] encodeBranch(input logic [2:0] f3, input logic [4:0] rs1,
                                                 input logic [4:0] rs2, input logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] encodeJal(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPCODE_JAL};
    endfunction

    function automatic memFwdS memView(input logic wr, input logic [4:0] rd, input logic [31:0] alu,
                                       input logic csrEn, input logic [31:0] csr);
        return {wr, rd, alu, csrEn, csr};
    endfunction

    function automatic wbFwdS wbView(input logic wr, input logic [4:0] rd, input logic [31:0] dmem,
                                     input logic [31:0] alu, input logic [31:0] pc,
                                     input logic [1:0] sel, input logic csrEn,
                                     input logic [31:0] csr);
        return {wr, rd, dmem, alu, pc, sel, csrEn, csr};
    endfunction

    function automatic logic expectTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        logic res;
        case (f3)
            3'd0:    res = (a == b);
            3'd1:    res = (a != b);
            3'd4:    res = ($signed(a) < $signed(b));
            3'd5:    res = ($signed(a) >= $signed(b));
            3'd6:    res = (a < b);
            3'd7:    res = (a >= b);
            default: res = 1'b0;
        endcase
        return res;
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %0h actual %0h", testName, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic addEntry(input string name, input logic [31:0] pc, input logic [31:0] word,
                            input logic [31:0] r1, input logic [31:0] r2, input memFwdS mem,
                            input wbFwdS wb, input logic expTaken, input logic [31:0] expTarget);
        vectorS v;
        v.name      = name;
        v.item      = {1'b1, pc, word, r1, r2};
        v.mem       = mem;
        v.wb        = wb;
        v.expTaken  = expTaken;
        v.expTarget = expTarget;
        vectors.push_back(v);
    endtask

    // Random conditions and offsets on register-file operands
    task automatic addRandom(input int count);
        logic [2:0]  cond;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] off;
        for (int k = 0; k < count; k++) begin
            cond = condList[3'($urandom_range(5, 0))];
            a    = $urandom();
            // Every third pair equal
            b    = (k % 3 == 0) ? a : $urandom();
            pc   = $urandom() & 32'hFFFF_FFFC;
            off  = $urandom() & 32'h0000_1FFC;
            off  = {{19{off[12]}}, off[12:0]};
            addEntry($sformatf("random_%0d", k), pc, encodeBranch(cond, 5'd5, 5'd6, off), a, b,
                     '0, '0, expectTaken(cond, a, b), pc + off);
        end
    endtask

    task automatic watchdog(input int entries);
        int cycles;
        cycles = entries * 4 + RESET_CYCLES;
        #(cycles * CLK_PERIOD);
        $display("timeout after %0d cycles, the test loop did not finish", cycles);
        $display("Result: FAILED");
        $fatal(1, "simulation timed out");
    endtask

    initial begin
        memStage = '0;
        wbStage  = '0;
        // Taken BEQ held at the input while reset is asserted
        branchIn = {1'b1, PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 32'd7, 32'd7};
        void'($urandom(72));

        addEntry("invalid_first", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 7, 7, '0, '0, 1'b0, 0);
        vectors[vectors.size() - 1].item.valid = 1'b0;
        addEntry("beq_equal", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 7, 7, '0, '0,
                 1'b1, PC0 + 16);
        addEntry("beq_differ", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 7, 8, '0, '0, 1'b0, 0);
        addEntry("bne_differ", PC0, encodeBranch(3'd1, 5'd5, 5'd6, 16), 7, 8, '0, '0,
                 1'b1, PC0 + 16);
        addEntry("blt_neg_pos", PC0, encodeBranch(3'd4, 5'd5, 5'd6, 16), -5, 3, '0, '0,
                 1'b1, PC0 + 16);
        addEntry("bltu_neg_pos", PC0, encodeBranch(3'd6, 5'd5, 5'd6, 16), -5, 3, '0, '0, 1'b0, 0);
        addEntry("bge_neg_pos", PC0, encodeBranch(3'd5, 5'd5, 5'd6, 16), -5, 3, '0, '0, 1'b0, 0);
        addEntry("bgeu_neg_pos", PC0, encodeBranch(3'd7, 5'd5, 5'd6, 16), -5, 3, '0, '0,
                 1'b1, PC0 + 16);
        addEntry("bge_equal", PC0, encodeBranch(3'd5, 5'd5, 5'd6, 16), 3, 3, '0, '0,
                 1'b1, PC0 + 16);

        // MEM forwarding with CSR over ALU
        addEntry("mem_alu_a", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 0, 9,
                 memView(1'b1, 5'd5, 9, 1'b0, 0), '0, 1'b1, PC0 + 16);
        addEntry("mem_csr_a", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 0, 12,
                 memView(1'b1, 5'd5, 9, 1'b1, 12), '0, 1'b1, PC0 + 16);
        addEntry("mem_alu_b", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 9, 0,
                 memView(1'b1, 5'd6, 9, 1'b0, 0), '0, 1'b1, PC0 + 16);
        addEntry("mem_both", PC0, encodeBranch(3'd0, 5'd5, 5'd5, 16), 1, 2,
                 memView(1'b1, 5'd5, 9, 1'b0, 0), '0, 1'b1, PC0 + 16);

        // WB forwarding by wbSel and CSR
        addEntry("wb_dmem", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 0, 20, '0,
                 wbView(1'b1, 5'd5, 20, 21, 32'h200, 2'd0, 1'b0, 0), 1'b1, PC0 + 16);
        addEntry("wb_alu", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 0, 21, '0,
                 wbView(1'b1, 5'd5, 20, 21, 32'h200, 2'd1, 1'b0, 0), 1'b1, PC0 + 16);
        addEntry("wb_link", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 0, 32'h204, '0,
                 wbView(1'b1, 5'd5, 20, 21, 32'h200, 2'd2, 1'b0, 0), 1'b1, PC0 + 16);
        addEntry("wb_csr", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 0, 33, '0,
                 wbView(1'b1, 5'd5, 20, 21, 32'h200, 2'd0, 1'b1, 33), 1'b1, PC0 + 16);

        // Priority and suppression
        addEntry("mem_over_wb", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 0, 9,
                 memView(1'b1, 5'd5, 9, 1'b0, 0),
                 wbView(1'b1, 5'd5, 20, 21, 32'h200, 2'd1, 1'b0, 0), 1'b1, PC0 + 16);
        addEntry("rd_zero", PC0, encodeBranch(3'd0, 5'd0, 5'd6, 16), 0, 0,
                 memView(1'b1, 5'd0, 9, 1'b0, 0),
                 wbView(1'b1, 5'd0, 20, 21, 32'h200, 2'd1, 1'b0, 0), 1'b1, PC0 + 16);
        addEntry("regwrite_low", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16), 0, 0,
                 memView(1'b0, 5'd5, 9, 1'b0, 0),
                 wbView(1'b0, 5'd6, 20, 21, 32'h200, 2'd1, 1'b0, 0), 1'b1, PC0 + 16);

        // Targets followed by decode cases without a redirect
        addEntry("jal_forward", PC0, encodeJal(5'd1, 32'h12344), 0, 1, '0, '0, 1'b1, 32'h13344);
        addEntry("jal_back", PC0, encodeJal(5'd1, -256), 0, 1, '0, '0, 1'b1, 32'h0F00);
        addEntry("beq_back", PC0, encodeBranch(3'd0, 5'd5, 5'd6, -2048), 7, 7, '0, '0,
                 1'b1, 32'h0800);
        // OP-IMM opcode in place of BRANCH
        addEntry("not_branch", PC0, encodeBranch(3'd0, 5'd5, 5'd6, 16) ^ 32'h70, 7, 7, '0, '0,
                 1'b0, 0);
        addEntry("reserved_f3", PC0, encodeBranch(3'd2, 5'd5, 5'd6, 16), 7, 7, '0, '0, 1'b0, 0);
        addEntry("invalid_jal", PC0, encodeJal(5'd1, 64), 0, 0, '0, '0, 1'b0, 0);
        vectors[vectors.size() - 1].item.valid = 1'b0;
        addRandom(12);

        fork
            watchdog(vectors.size());
        join_none

        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            @(negedge clk);
            checkValue("reset", 32'd0, {31'd0, redirect.valid});
            checkValue("reset target", 32'd0, redirect.target);
        end
        branchIn = '0;
        @(posedge rstN);

        // Check the previous entry, then drive the next one
        for (int i = 0; i <= vectors.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                checkValue(vectors[i - 1].name, {31'd0, vectors[i - 1].expTaken},
                           {31'd0, redirect.valid});
                if (vectors[i - 1].expTaken) begin
                    checkValue({vectors[i - 1].name, " target"}, vectors[i - 1].expTarget,
                               redirect.target);
                end
            end
            if (i < vectors.size()) begin
                branchIn = vectors[i].item;
                memStage = vectors[i].mem;
                wbStage  = vectors[i].wb;
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- bench/idBranch_checker.sv
`timescale 1ns/10ps

`include "branch_defines.svh"

module idBranchChecker import branchPkg::*; (
    input logic     clk,
    input logic     rstN,
    input idBranchS branchIn,
    input redirectS redirect
);

    logic controlItem;

    // Valid item with a branch or JAL opcode
    assign controlItem = branchIn.valid &&
                         ((branchIn.instr.b.opcode == `OPCODE_BRANCH) ||
                          (branchIn.instr.j.opcode == `OPCODE_JAL));

    // Two pulses in a row need two branch or jump items in a row
    assert property (@(posedge clk) disable iff (!rstN)
        redirect.valid && $past(redirect.valid) |-> $past(controlItem) && $past(controlItem, 2))
        else $error("redirect held high without back-to-back branch items");

    assert property (@(posedge clk) !rstN |-> !redirect.valid)
        else $error("redirect valid while reset is asserted");

    // Instruction addresses are word aligned
    assert property (@(posedge clk) disable iff (!rstN)
        redirect.valid |-> redirect.target[1:0] == 2'b00)
        else $error("redirect target is not word aligned");

endmodule

bind idBranchTop idBranchChecker idBranchChecker_i (
    .clk      (clk),
    .rstN     (rstN),
    .branchIn (branchIn),
    .redirect (redirect)
);

//--- bench/idBranchClock.sv
`timescale 1ns/10ps

module idBranchClock (
    output logic clk,
    output logic rstN
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for 4 cycles and released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

//--- verilog/idBranchTop.sv
`timescale 1ns/10ps

module idBranchTop import branchPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  idBranchS branchIn,
    input  memFwdS   memStage,
    input  wbFwdS    wbStage,
    output redirectS redirect
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////////////////////

    fwdSelE fwdSelA;
    fwdSelE fwdSelB;
    logic   equal;
    logic   lessThan;
    logic   unsignedCmp;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////////////////////////////////////////

    branchForwardUnit branchForwardUnit_i (
        .branchIn (branchIn),
        .memStage (memStage),
        .wbStage  (wbStage),
        .fwdSelA  (fwdSelA),
        .fwdSelB  (fwdSelB)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Operand select and compare
    ////////////////////////////////////////////////////////////////////////////

    branchComp branchComp_i (
        .branchIn    (branchIn),
        .memStage    (memStage),
        .wbStage     (wbStage),
        .fwdSelA     (fwdSelA),
        .fwdSelB     (fwdSelB),
        .unsignedCmp (unsignedCmp),
        .equal       (equal),
        .lessThan    (lessThan)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Decision and redirect register
    ////////////////////////////////////////////////////////////////////////////

    branchDecide branchDecide_i (
        .clk         (clk),
        .rstN        (rstN),
        .branchIn    (branchIn),
        .equal       (equal),
        .lessThan    (lessThan),
        .unsignedCmp (unsignedCmp),
        .redirect    (redirect)
    );

endmodule

//--- verilog/branchDecide.sv
`timescale 1ns/10ps

`include "branch_defines.svh"

module branchDecide import branchPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  idBranchS branchIn,
    input  logic     equal,
    input  logic     lessThan,
    output logic     unsignedCmp,
    output redirectS redirect
);

    bTypeS            bView;
    jTypeS            jView;
    logic             isBranch;
    logic             isJal;
    logic             condTrue;
    logic             taken;
    logic [`XLEN-1:0] bImm;
    logic [`XLEN-1:0] jImm;
    logic [`XLEN-1:0] targetNext;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////////////////////////////////////////

    assign bView = branchIn.instr.b;
    assign jView = branchIn.instr.j;

    assign isBranch = (bView.opcode == `OPCODE_BRANCH);
    assign isJal    = (jView.opcode == `OPCODE_JAL);

    // BLTU and BGEU
    assign unsignedCmp = bView.funct3[2] & bView.funct3[1];

    // Immediates with bit 0 always zero
    assign bImm = {{(`XLEN-13){bView.imm12}}, bView.imm12, bView.imm11,
                   bView.imm10_5, bView.imm4_1, 1'b0};
    assign jImm = {{(`XLEN-21){jView.imm20}}, jView.imm20, jView.imm19_12,
                   jView.imm11, jView.imm10_1, 1'b0};

    assign targetNext = branchIn.pc + (isJal ? jImm : bImm);

    ////////////////////////////////////////////////////////////////////////////
    // Taken rule
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (bView.funct3)
            3'b000:  condTrue = equal;
            3'b001:  condTrue = !equal;
            3'b100:  condTrue = lessThan;
            3'b101:  condTrue = !lessThan;
            3'b110:  condTrue = lessThan;
            3'b111:  condTrue = !lessThan;
            // Reserved encodings
            default: condTrue = 1'b0;
        endcase
    end

    assign taken = branchIn.valid && (isJal || (isBranch && condTrue));

    ////////////////////////////////////////////////////////////////////////////
    // Redirect register
    ////////////////////////////////////////////////////////////////////////////

    // One-cycle pulse while the target holds the last redirect
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            redirect <= '0;
        end else begin
            redirect.valid <= taken;
            if (taken) begin
                redirect.target <= targetNext;
            end
        end
    end

endmodule

//--- verilog/branchComp.sv
`timescale 1ns/10ps

`include "branch_defines.svh"

module branchComp import branchPkg::*; (
    input  idBranchS branchIn,
    input  memFwdS   memStage,
    input  wbFwdS    wbStage,
    input  fwdSelE   fwdSelA,
    input  fwdSelE   fwdSelB,
    input  logic     unsignedCmp,
    output logic     equal,
    output logic     lessThan
);

    logic [`XLEN-1:0] memValue;
    logic [`XLEN-1:0] wbValue;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;

    ////////////////////////////////////////////////////////////////////////////
    // Forward values
    ////////////////////////////////////////////////////////////////////////////

    // CSR read beats the ALU result
    assign memValue = memStage.csrRegEn ? memStage.csrResult : memStage.aluResult;

    always_comb begin
        if (wbStage.csrRegEn) begin
            wbValue = wbStage.csrResult;
        end else begin
            case (wbStage.wbSel)
                2'd0:    wbValue = wbStage.dmem;
                2'd1:    wbValue = wbStage.alu;
                // Link value of a jump
                default: wbValue = wbStage.pc + `XLEN'(`PC_STEP);
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operand muxes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (fwdSelA)
            FWD_MEM: opA = memValue;
            FWD_WB:  opA = wbValue;
            default: opA = branchIn.rdata1;
        endcase
        case (fwdSelB)
            FWD_MEM: opB = memValue;
            FWD_WB:  opB = wbValue;
            default: opB = branchIn.rdata2;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////////////////////////////

    assign equal    = (opA == opB);
    assign lessThan = unsignedCmp ? (opA < opB) : ($signed(opA) < $signed(opB));

endmodule

//--- verilog/branchForwardUnit.sv
`timescale 1ns/10ps

`include "branch_defines.svh"

module branchForwardUnit import branchPkg::*; (
    input  idBranchS branchIn,
    input  memFwdS   memStage,
    input  wbFwdS    wbStage,
    output fwdSelE   fwdSelA,
    output fwdSelE   fwdSelB
);

    ////////////////////////////////////////////////////////////////////////////
    // Hazard check for one source register
    ////////////////////////////////////////////////////////////////////////////

    // MEM holds the younger result, so it is checked first
    function automatic fwdSelE selectSource(
        input logic [`REG_ADDR_W-1:0] rs,
        input memFwdS                 mem,
        input wbFwdS                  wb
    );
        fwdSelE sel;
        logic   memHit;
        logic   wbHit;
        memHit = mem.regWrite && (mem.rd != '0) && (mem.rd == rs);
        wbHit  = wb.regWrite && (wb.rd != '0) && (wb.rd == rs);
        if (memHit) begin
            sel = FWD_MEM;
        end else if (wbHit) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Source registers
    ////////////////////////////////////////////////////////////////////////////

    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;

    // Read through the B-type view even for JAL
    assign rs1 = branchIn.instr.b.rs1;
    assign rs2 = branchIn.instr.b.rs2;

    ////////////////////////////////////////////////////////////////////////////
    // Select outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        fwdSelA = selectSource(rs1, memStage, wbStage);
        fwdSelB = selectSource(rs2, memStage, wbStage);
    end

endmodule

//--- verilog/branchPkg.sv
`include "branch_defines.svh"

package branchPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Operand source select
    ////////////////////////////////////////////////////////////////////////////

    // Bit 1 picks MEM, bit 0 picks WB
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwdSelE;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [6:0]             opcode;
    } bTypeS;

    typedef struct packed {
        logic                   imm20;
        logic [9:0]             imm10_1;
        logic                   imm11;
        logic [7:0]             imm19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } jTypeS;

    // Opcode sits in the same bits of both views
    typedef union packed {
        bTypeS b;
        jTypeS j;
    } instrWordU;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline views
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        instrWordU        instr;
        logic [`XLEN-1:0] rdata1;
        logic [`XLEN-1:0] rdata2;
    } idBranchS;

    typedef struct packed {
        logic                   regWrite;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       aluResult;
        logic                   csrRegEn;
        logic [`XLEN-1:0]       csrResult;
    } memFwdS;

    typedef struct packed {
        logic                   regWrite;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       dmem;
        logic [`XLEN-1:0]       alu;
        logic [`XLEN-1:0]       pc;
        logic [1:0]             wbSel;
        logic                   csrRegEn;
        logic [`XLEN-1:0]       csrResult;
    } wbFwdS;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirectS;

endpackage

//--- verilog/branch_defines.svh
`ifndef BRANCH_DEFINES_SVH
`define BRANCH_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Data and address width
`define XLEN 32

// Register number width
`define REG_ADDR_W 5

////////////////////////////////////////////////////////////////////////////
// Opcodes and constants
////////////////////////////////////////////////////////////////////////////

`define OPCODE_BRANCH 7'b1100011
`define OPCODE_JAL 7'b1101111

// Link value step for the WB PC
`define PC_STEP 4

`endif
